// ==== Makefile ====
TOP := tb_mips_lite

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)
	./obj_dir/V$(TOP) | awk '{ print } /^TESTS PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== logic/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

////////////////////////////////////////
// core build parameters
////////////////////////////////////////

// first fetch address, the usual boot vector of the kseg1 rom
`define CORE_RESET_PC 32'hbfc0_0000

`define CORE_XLEN  32 // data and address width
`define CORE_NREGS 32 // architectural register count

`endif

// ==== logic/core_pkg.sv ====
`include "core_config.svh"

package core_pkg;

    ////////////////////////////////////////
    // basic words
    ////////////////////////////////////////

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [4:0]            reg_idx_t;

    // major opcode field, only the subset this core knows
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_NOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_e;

    // r-type view, the immediate is the low half (rd, shamt, funct)
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic [4:0] shamt;
        funct_e   funct;
    } inst_t;

endpackage

// ==== logic/decode_exec.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module decode_exec (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               fetch_valid_i,
    input  core_pkg::word_t    fetch_pc_i,
    input  core_pkg::inst_t    fetch_inst_i,
    input  core_pkg::word_t    rs_data_i,
    input  core_pkg::word_t    rt_data_i,
    output core_pkg::reg_idx_t rs_idx_o,
    output core_pkg::reg_idx_t rt_idx_o,
    wb_if.src                  wb
);
    import core_pkg::*;

    alu_op_e   alu_op;
    logic      supported;
    logic      use_imm;
    reg_idx_t  dest;
    word_t     imm_ext;
    logic [15:0] imm;
    word_t     opb;
    word_t     result;

    logic      wen_q;
    reg_idx_t  waddr_q;
    word_t     wdata_q;
    word_t     pc_q;

    assign rs_idx_o = fetch_inst_i.rs;
    assign rt_idx_o = fetch_inst_i.rt;
    assign imm      = {fetch_inst_i.rd, fetch_inst_i.shamt, fetch_inst_i.funct};

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////

    always_comb begin
        alu_op    = ALU_ADD;
        supported = 1'b1;
        use_imm   = 1'b1;
        dest      = fetch_inst_i.rt; // i-type writes rt
        imm_ext   = {{(`CORE_XLEN-16){1'b0}}, imm};
        case (fetch_inst_i.opcode)
            OP_SPECIAL: begin
                use_imm = 1'b0;
                dest    = fetch_inst_i.rd;
                case (fetch_inst_i.funct)
                    F_ADDU:  alu_op = ALU_ADD;
                    F_SUBU:  alu_op = ALU_SUB;
                    F_AND:   alu_op = ALU_AND;
                    F_OR:    alu_op = ALU_OR;
                    F_XOR:   alu_op = ALU_XOR;
                    F_NOR:   alu_op = ALU_NOR;
                    F_SLT:   alu_op = ALU_SLT;
                    F_SLL:   alu_op = ALU_SLL;
                    F_SRL:   alu_op = ALU_SRL;
                    default: supported = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                alu_op  = ALU_ADD;
                imm_ext = {{(`CORE_XLEN-16){imm[15]}}, imm}; // only addiu sign-extends
            end
            OP_ANDI: alu_op = ALU_AND;
            OP_ORI:  alu_op = ALU_OR;
            OP_XORI: alu_op = ALU_XOR;
            OP_LUI: begin
                alu_op  = ALU_LUI;
                imm_ext = {imm, 16'b0};
            end
            default: supported = 1'b0; // anything else retires as a no-op
        endcase
    end

    ////////////////////////////////////////
    // alu
    ////////////////////////////////////////

    assign opb = use_imm ? imm_ext : rt_data_i;

    always_comb begin
        case (alu_op)
            ALU_ADD: result = rs_data_i + opb;
            ALU_SUB: result = rs_data_i - opb;
            ALU_AND: result = rs_data_i & opb;
            ALU_OR:  result = rs_data_i | opb;
            ALU_XOR: result = rs_data_i ^ opb;
            ALU_NOR: result = ~(rs_data_i | opb);
            ALU_SLT: result = {{(`CORE_XLEN-1){1'b0}}, $signed(rs_data_i) < $signed(opb)};
            ALU_SLL: result = opb << fetch_inst_i.shamt; // shifts act on rt
            ALU_SRL: result = opb >> fetch_inst_i.shamt;
            ALU_LUI: result = opb;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wen_q <= 1'b0;
        end else begin
            wen_q <= fetch_valid_i && supported && dest != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid_i) begin
            waddr_q <= dest;
            wdata_q <= result;
            pc_q    <= fetch_pc_i;
        end
    end

    assign wb.wen   = wen_q;
    assign wb.waddr = waddr_q;
    assign wb.wdata = wdata_q;
    assign wb.pc    = pc_q;

    // ifetch never delivers on two cycles in a row, so each write-back lasts one cycle
    fetch_gap_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        fetch_valid_i |=> !fetch_valid_i);

endmodule

// ==== logic/ifetch.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module ifetch (
    input  logic            clk,
    input  logic            arst_n_i,

    // sram-like instruction bus
    output logic            inst_req_o,
    output core_pkg::word_t inst_addr_o,
    input  core_pkg::word_t inst_rdata_i,
    input  logic            inst_addr_ok_i,
    input  logic            inst_data_ok_i,

    // one instruction at a time towards decode
    output logic            fetch_valid_o,
    output core_pkg::word_t fetch_pc_o,
    output core_pkg::inst_t fetch_inst_o
);
    import core_pkg::*;

    typedef enum logic {
        S_REQ,
        S_WAIT
    } state_e;

    state_e state_q;
    logic   req_q;
    word_t  pc_q;
    logic   valid_q;
    word_t  fpc_q;
    inst_t  inst_q;

    ////////////////////////////////////////
    // request / response sequencer
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_REQ;
            req_q   <= 1'b0; // first request goes out one edge after release
            pc_q    <= `CORE_RESET_PC;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                S_REQ: begin
                    if (req_q && inst_addr_ok_i) begin
                        state_q <= S_WAIT;
                        req_q   <= 1'b0; // only one request in flight
                    end else begin
                        req_q <= 1'b1;
                    end
                end
                S_WAIT: begin
                    if (inst_data_ok_i) begin
                        state_q <= S_REQ;
                        req_q   <= 1'b1;
                        valid_q <= 1'b1;
                        pc_q    <= pc_q + 32'd4; // no branches, so the pc only steps
                    end
                end
                default: state_q <= S_REQ;
            endcase
        end
    end

    // response word and its pc, only meaningful while valid_q is high
    always_ff @(posedge clk) begin
        if (state_q == S_WAIT && inst_data_ok_i) begin
            inst_q <= inst_t'(inst_rdata_i);
            fpc_q  <= pc_q;
        end
    end

    assign inst_req_o    = req_q;
    assign inst_addr_o   = pc_q;
    assign fetch_valid_o = valid_q;
    assign fetch_pc_o    = fpc_q;
    assign fetch_inst_o  = inst_q;

    // a pending request must not change under the slave's feet
    addr_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        (inst_req_o && !inst_addr_ok_i) |=> (inst_req_o && $stable(inst_addr_o)));

endmodule

// ==== logic/mips_lite.sv ====
`timescale 1ns/1ps

module mips_lite (
    input  logic               clk,
    input  logic               arst_n_i,

    // inst sram-like
    output logic               inst_req_o,
    output core_pkg::word_t    inst_addr_o,
    input  core_pkg::word_t    inst_rdata_i,
    input  logic               inst_addr_ok_i,
    input  logic               inst_data_ok_i,

    // debug write-back trace
    output core_pkg::word_t    debug_wb_pc_o,
    output logic [3:0]         debug_wb_rf_wen_o,
    output core_pkg::reg_idx_t debug_wb_rf_wnum_o,
    output core_pkg::word_t    debug_wb_rf_wdata_o
);
    import core_pkg::*;

    logic     fetch_valid;
    word_t    fetch_pc;
    inst_t    fetch_inst;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_data;
    word_t    rt_data;

    wb_if u_wb ();

    ifetch u_ifetch (
        .clk(clk), .arst_n_i(arst_n_i),
        .inst_req_o(inst_req_o), .inst_addr_o(inst_addr_o),
        .inst_rdata_i(inst_rdata_i), .inst_addr_ok_i(inst_addr_ok_i),
        .inst_data_ok_i(inst_data_ok_i),
        .fetch_valid_o(fetch_valid), .fetch_pc_o(fetch_pc), .fetch_inst_o(fetch_inst)
    );

    // operands are read combinationally while decode looks at the instruction
    regfile u_regfile (
        .clk(clk), .arst_n_i(arst_n_i),
        .rs_idx_i(rs_idx), .rt_idx_i(rt_idx), .wb(u_wb.dst),
        .rs_data_o(rs_data), .rt_data_o(rt_data)
    );

    decode_exec u_decode_exec (
        .clk(clk), .arst_n_i(arst_n_i),
        .fetch_valid_i(fetch_valid), .fetch_pc_i(fetch_pc), .fetch_inst_i(fetch_inst),
        .rs_data_i(rs_data), .rt_data_i(rt_data),
        .rs_idx_o(rs_idx), .rt_idx_o(rt_idx), .wb(u_wb.src)
    );

    assign debug_wb_pc_o       = u_wb.pc;
    assign debug_wb_rf_wen_o   = {4{u_wb.wen}}; // all byte lanes or none
    assign debug_wb_rf_wnum_o  = u_wb.waddr;
    assign debug_wb_rf_wdata_o = u_wb.wdata;

endmodule

// ==== logic/regfile.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module regfile (
    input  logic               clk,
    input  logic               arst_n_i,
    input  core_pkg::reg_idx_t rs_idx_i,
    input  core_pkg::reg_idx_t rt_idx_i,
    wb_if.dst                  wb,
    output core_pkg::word_t    rs_data_o,
    output core_pkg::word_t    rt_data_o
);
    import core_pkg::*;

    word_t regs [`CORE_NREGS];

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wen && wb.waddr != '0) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    // $zero reads as zero, a write in the same cycle is forwarded
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb.wen && wb.waddr == idx) begin
            return wb.wdata; // write-through, saves a stall on back-to-back use
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs_data_o = read_port(rs_idx_i);
        rt_data_o = read_port(rt_idx_i);
    end

    // decode is expected to drop writes to $zero before they get here
    no_zero_write_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(wb.wen && wb.waddr == '0));

endmodule

// ==== logic/wb_if.sv ====
`timescale 1ns/1ps

// one write-back event, valid for a single cycle while wen is high
interface wb_if;
    import core_pkg::*;

    logic     wen;
    reg_idx_t waddr;
    word_t    wdata;
    word_t    pc; // pc of the instruction that produced the result

    modport src (
        output wen, waddr, wdata, pc
    );

    modport dst (
        input wen, waddr, wdata
    );

    // debug trace side sees the pc as well
    modport mon (
        input wen, waddr, wdata, pc
    );

endinterface

// ==== sim.f ====
+incdir+logic
logic/core_pkg.sv
logic/wb_if.sv
logic/ifetch.sv
logic/regfile.sv
logic/decode_exec.sv
logic/mips_lite.sv
verif/tb_mips_lite.sv

// ==== verif/tb_mips_lite.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module tb_mips_lite;
    import core_pkg::*;

    localparam int PROG_LEN = 300;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        word_t    data;
    } wb_rec_t;

    logic       clk, arst_n_i, inst_req_o, inst_addr_ok_i, inst_data_ok_i;
    word_t      inst_addr_o, inst_rdata_i, debug_wb_pc_o, debug_wb_rf_wdata_o;
    logic [3:0] debug_wb_rf_wen_o;
    reg_idx_t   debug_wb_rf_wnum_o;

    word_t   prog_mem [PROG_LEN];
    word_t   ref_regs [`CORE_NREGS]; // architectural state of the reference model
    wb_rec_t exp_q [$];
    int      served;

    mips_lite DUT (.*);

    always #4 clk = ~clk;

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic mismatch(input string test, input word_t expected, input word_t actual);
        fail_now($sformatf("Mismatch %s: expected %h, actual %h", test, expected, actual));
    endtask

    ////////////////////////////////////////
    // program and reference model
    ////////////////////////////////////////

    // rs and rt often reuse the previous destination to build dependent runs
    function automatic word_t gen_inst(input reg_idx_t prev);
        funct_e      fns [9];
        opcode_e     ops [5];
        funct_e      fn;
        reg_idx_t    rs;
        reg_idx_t    rt;
        int unsigned pick;
        fns  = '{F_ADDU, F_SUBU, F_AND, F_OR, F_XOR, F_NOR, F_SLT, F_SLL, F_SRL};
        ops  = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
        rs   = ($urandom_range(2, 0) == 0) ? prev : 5'($urandom);
        rt   = ($urandom_range(3, 0) == 0) ? prev : 5'($urandom);
        fn   = fns[4'($urandom_range(8, 0))];
        pick = $urandom_range(99, 0);
        if (pick < 5)
            return {6'h23, rs, rt, 16'($urandom)}; // lw is outside the subset
        if (pick < 50)
            return {OP_SPECIAL, rs, rt, 5'($urandom), 5'($urandom), fn};
        return {ops[3'($urandom_range(4, 0))], rs, rt, 16'($urandom)};
    endfunction

    // returns the register written, zero when the instruction writes nothing
    function automatic reg_idx_t run_model(input word_t w, input word_t pc);
        inst_t    i;
        word_t    a;
        word_t    b;
        word_t    res;
        reg_idx_t dest;
        i    = inst_t'(w);
        a    = ref_regs[i.rs];
        b    = ref_regs[i.rt];
        res  = '0;
        dest = (i.opcode == OP_SPECIAL) ? i.rd : i.rt;
        case (i.opcode)
            OP_SPECIAL: case (i.funct)
                F_ADDU:  res = a + b;
                F_SUBU:  res = a - b;
                F_AND:   res = a & b;
                F_OR:    res = a | b;
                F_XOR:   res = a ^ b;
                F_NOR:   res = ~(a | b);
                F_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                F_SLL:   res = b << i.shamt;
                F_SRL:   res = b >> i.shamt;
                default: dest = '0;
            endcase
            OP_ADDIU: res = a + {{16{w[15]}}, w[15:0]};
            OP_ANDI:  res = a & {16'h0, w[15:0]};
            OP_ORI:   res = a | {16'h0, w[15:0]};
            OP_XORI:  res = a ^ {16'h0, w[15:0]};
            OP_LUI:   res = {w[15:0], 16'h0};
            default:  dest = '0;
        endcase
        if (dest != '0) begin
            ref_regs[dest] = res;
            exp_q.push_back('{pc: pc, rd: dest, data: res});
        end
        return dest;
    endfunction

    ////////////////////////////////////////
    // bus model and write-back monitor
    ////////////////////////////////////////

    task automatic serve_bus();
        word_t       next_addr;
        word_t       addr;
        word_t       idx;
        int unsigned wait_n;
        next_addr = `CORE_RESET_PC;
        forever begin
            while (!inst_req_o)
                step();
            addr = inst_addr_o;
            assert (addr == next_addr) else mismatch("fetch_order", next_addr, addr);
            repeat ($urandom_range(3, 0)) begin
                step();
                assert (inst_req_o && inst_addr_o == addr) else
                    fail_now("request dropped or address changed before acceptance");
            end
            inst_addr_ok_i = 1'b1;
            step();
            inst_addr_ok_i = 1'b0;
            wait_n = $urandom_range(3, 0); // response comes 1 to 4 cycles after acceptance
            for (int k = 0; k <= int'(wait_n); k++) begin
                assert (!inst_req_o) else
                    fail_now("new request raised while a response was still pending");
                if (k < int'(wait_n))
                    step();
            end
            idx = (addr - `CORE_RESET_PC) >> 2;
            inst_rdata_i   = (idx < PROG_LEN) ? prog_mem[idx[8:0]] : '0; // nops past the end
            inst_data_ok_i = 1'b1;
            step();
            inst_data_ok_i = 1'b0;
            served++;
            next_addr = addr + 32'd4;
        end
    endtask

    task automatic watch_writeback();
        forever begin
            step();
            if (debug_wb_rf_wen_o != 4'h0) begin
                assert (exp_q.size() != 0 && debug_wb_rf_wen_o == 4'hf) else
                    fail_now("write-back seen where the model expects none");
                assert (debug_wb_pc_o == exp_q[0].pc) else
                    mismatch("writeback_pc", exp_q[0].pc, debug_wb_pc_o);
                assert (debug_wb_rf_wnum_o == exp_q[0].rd) else
                    mismatch("writeback_reg", 32'(exp_q[0].rd), 32'(debug_wb_rf_wnum_o));
                assert (debug_wb_rf_wdata_o == exp_q[0].data) else
                    mismatch("alu_result", exp_q[0].data, debug_wb_rf_wdata_o);
                void'(exp_q.pop_front());
            end
        end
    endtask

    initial begin
        reg_idx_t prev;
        void'($urandom(32'hcad9));
        clk            = 1'b0;
        arst_n_i       = 1'b0;
        inst_rdata_i   = '0;
        inst_addr_ok_i = 1'b0;
        inst_data_ok_i = 1'b0;
        served         = 0;
        prev           = '0;
        for (int r = 0; r < `CORE_NREGS; r++)
            ref_regs[r] = '0;
        for (int n = 0; n < PROG_LEN; n++) begin
            prog_mem[n] = gen_inst(prev);
            prev = run_model(prog_mem[n], `CORE_RESET_PC + 32'(n * 4));
        end
        repeat (3) begin
            step();
            assert (!inst_req_o && debug_wb_rf_wen_o == 4'h0) else
                fail_now("request or write enable active during reset");
        end
        arst_n_i = 1'b1;
        fork
            serve_bus();
            watch_writeback();
        join_none
        wait (served >= PROG_LEN + 4); // trailing nops let the last write-back drain
        step();
        if (exp_q.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            fail_now($sformatf("%0d expected write-backs never appeared", exp_q.size()));
        end
    end

    initial begin
        repeat (PROG_LEN * 12) @(posedge clk);
        fail_now("watchdog expired before the program retired");
    end

endmodule
